/* flist.f */
design/lcmgr_pkg.sv
design/seed_reader.sv
design/rma_wiper.sv
design/lcmgr_ctrl.sv
design/flash_lcmgr.sv
verification/flash_model.sv
verification/tb_flash_lcmgr.sv

/* Bender.yml */
package:
  name: flash_lcmgr

sources:
  - design/lcmgr_pkg.sv
  - design/seed_reader.sv
  - design/rma_wiper.sv
  - design/lcmgr_ctrl.sv
  - design/flash_lcmgr.sv
  - target: simulation
    files:
      - verification/flash_model.sv
      - verification/tb_flash_lcmgr.sv

/* verification/tb_flash_lcmgr.sv */
// Flash life-cycle manager testbench
`timescale 1ns/1ns

module tb_flash_lcmgr import lcmgr_pkg::*; ();

  localparam int unsigned BusWidth     = DefBusWidth;
  localparam int unsigned BurstWords   = DefBurstWords;
  localparam int unsigned NumSeeds     = DefNumSeeds;
  localparam int unsigned WordsPerPage = DefWordsPerPage;
  localparam int unsigned WipePages    = DefWipePages;
  localparam int unsigned AddrWidth    = DefAddrWidth;
  localparam int WaitCycles  = 5000;
  localparam int QuietCycles = 200;
  localparam int WipeWords   = WipePages * WordsPerPage;
  // bit positions in status
  localparam int IdxBusy    = 0;
  localparam int IdxInit    = 1;
  localparam int IdxSeedErr = 2;
  localparam int IdxAck     = 3;
  localparam int IdxFatal   = 4;
  localparam int IdxReq     = 5;

  logic clk, rst_n;
  logic init, provision_en, rma_req;
  logic rma_ack, dis_access, initialized, init_busy, seed_err, fatal_err;
  logic [NumSeeds*BurstWords*BusWidth-1:0] seeds;
  logic flash_req, flash_done, flash_err, flash_rvalid, flash_wvalid, flash_wready;
  flash_op_e flash_op, err_op, op_q;
  logic [AddrWidth-1:0] flash_addr, addr_q;
  logic [BusWidth-1:0] flash_rdata, flash_wdata, rand_d, wdata_q;
  logic err_en, flip_en, no_flash;
  logic hold_q, wd_hold_q, adv;
  logic [5:0] status;
  logic [BusWidth-1:0] exp_seed [NumSeeds*BurstWords];
  logic [BusWidth-1:0] exp_wipe [WipeWords];
  int beat_n;
  int errors;

  flash_lcmgr #(
    .BusWidth     (BusWidth),
    .BurstWords   (BurstWords),
    .NumSeeds     (NumSeeds),
    .WordsPerPage (WordsPerPage),
    .WipePages    (WipePages),
    .AddrWidth    (AddrWidth)
  ) dut_i (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .init_i         (init),
    .provision_en_i (provision_en),
    .rma_req_i      (rma_req),
    .rma_ack_o      (rma_ack),
    .dis_access_o   (dis_access),
    .initialized_o  (initialized),
    .init_busy_o    (init_busy),
    .seed_err_o     (seed_err),
    .fatal_err_o    (fatal_err),
    .seeds_o        (seeds),
    .flash_req_o    (flash_req),
    .flash_op_o     (flash_op),
    .flash_addr_o   (flash_addr),
    .flash_done_i   (flash_done),
    .flash_err_i    (flash_err),
    .flash_rvalid_i (flash_rvalid),
    .flash_rdata_i  (flash_rdata),
    .flash_wvalid_o (flash_wvalid),
    .flash_wready_i (flash_wready),
    .flash_wdata_o  (flash_wdata),
    .rand_i         (rand_d)
  );

  flash_model #(
    .BusWidth     (BusWidth),
    .BurstWords   (BurstWords),
    .WordsPerPage (WordsPerPage),
    .AddrWidth    (AddrWidth)
  ) u_flash (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .req_i     (flash_req),
    .op_i      (flash_op),
    .addr_i    (flash_addr),
    .wvalid_i  (flash_wvalid),
    .wdata_i   (flash_wdata),
    .err_en_i  (err_en),
    .err_op_i  (err_op),
    .flip_en_i (flip_en),
    .done_o    (flash_done),
    .err_o     (flash_err),
    .rvalid_o  (flash_rvalid),
    .rdata_o   (flash_rdata),
    .wready_o  (flash_wready)
  );

  assign status = {flash_req, fatal_err, rma_ack, seed_err, initialized, init_busy};

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // entropy only advances once a beat has taken the word
  always @(posedge clk) begin
    adv = !flash_wvalid || flash_wready;
    #1;
    if (adv) begin
      rand_d = $urandom;
    end
  end

  // entropy word offered in each accepted beat, by word address
  always @(posedge clk) begin
    if (!rst_n || flash_done) begin
      beat_n = 0;
    end else if (flash_wvalid && flash_wready) begin
      if (int'(flash_addr) + beat_n < WipeWords) begin
        exp_wipe[int'(flash_addr) + beat_n] = rand_d;
      end
      beat_n++;
    end
  end

  task automatic abort_run(string what);
    errors++;
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic flag_mismatch(string name, logic [BusWidth-1:0] got,
                               logic [BusWidth-1:0] exp);
    abort_run($sformatf("CHECK FAILED t=%0t %s got=%0h exp=%0h", $time, name, got, exp));
  endtask

  task automatic compare_value(string name, logic [BusWidth-1:0] got,
                               logic [BusWidth-1:0] exp);
    assert (got === exp) else flag_mismatch(name, got, exp);
  endtask

  ////////////////////////////////
  // protocol checks
  ////////////////////////////////
  assert property (@(posedge clk) disable iff (!rst_n) flash_done |=> !flash_req)
    else flag_mismatch("flash_req_o", $sampled(flash_req), '0);
  assert property (@(posedge clk) disable iff (!rst_n) no_flash |-> !flash_req)
    else flag_mismatch("flash_req_o", $sampled(flash_req), '0);
  assert property (@(posedge clk) disable iff (!rst_n) seed_err |=> seed_err)
    else flag_mismatch("seed_err_o", $sampled(seed_err), 1'b1);

  // request and stalled beat hold until taken
  always @(posedge clk) begin
    if (rst_n && hold_q) begin
      assert (flash_req) else flag_mismatch("flash_req_o", flash_req, 1'b1);
      assert (flash_op == op_q) else flag_mismatch("flash_op_o", flash_op, op_q);
      assert (flash_addr == addr_q) else flag_mismatch("flash_addr_o", flash_addr, addr_q);
    end
    if (rst_n && wd_hold_q) begin
      assert (flash_wvalid) else flag_mismatch("flash_wvalid_o", flash_wvalid, 1'b1);
      assert (flash_wdata == wdata_q) else flag_mismatch("flash_wdata_o", flash_wdata, wdata_q);
    end
    hold_q    = rst_n && flash_req && !flash_done;
    op_q      = flash_op;
    addr_q    = flash_addr;
    wd_hold_q = rst_n && flash_wvalid && !flash_wready;
    wdata_q   = flash_wdata;
  end

  task automatic apply_reset();
    rst_n        = 1'b0;
    init         = 1'b0;
    provision_en = 1'b0;
    rma_req      = 1'b0;
    err_en       = 1'b0;
    err_op       = FlashOpRead;
    flip_en      = 1'b0;
    no_flash     = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  task automatic wait_status(int idx, string name);
    int cnt;
    cnt = 0;
    while (!status[idx]) begin
      @(posedge clk);
      #1;
      cnt++;
      if (cnt > WaitCycles) begin
        abort_run($sformatf("timeout while waiting for %s to rise", name));
      end
    end
  endtask

  // two different passes per seed word
  task automatic load_seeds();
    logic [BusWidth-1:0] a, b;
    int unsigned w;
    for (int s = 0; s < NumSeeds; s++) begin
      for (int k = 0; k < BurstWords; k++) begin
        a = $urandom;
        b = $urandom;
        w = s * WordsPerPage + k;
        u_flash.mem_a[w] = a;
        u_flash.mem_b[w] = b;
        exp_seed[s * BurstWords + k] = a & b;
      end
    end
  endtask

  task automatic inspect_seeds(logic expect_zero);
    for (int i = 0; i < NumSeeds * BurstWords; i++) begin
      compare_value($sformatf("seeds_o word %0d", i), seeds[i*BusWidth +: BusWidth],
                    expect_zero ? '0 : exp_seed[i]);
    end
  endtask

  task automatic confirm_wiped();
    for (int w = 0; w < WipeWords; w++) begin
      compare_value($sformatf("erased and programmed flag of word %0d", w),
                    u_flash.prog_q[w], 1'b1);
      compare_value($sformatf("flash word %0d", w), u_flash.mem_a[w], exp_wipe[w]);
    end
  endtask

  task automatic hold_no_ack();
    for (int i = 0; i < QuietCycles; i++) begin
      @(posedge clk);
      #1;
      compare_value("rma_ack_o", rma_ack, 1'b0);
      compare_value("dis_access_o", dis_access, 1'b1);
    end
  endtask

  initial begin
    void'($urandom(32'h1ca7cf7d));
    errors = 0;
    rand_d = '0;
    apply_reset();

    // provisioned seed read
    load_seeds();
    provision_en = 1'b1;
    init         = 1'b1;
    wait_status(IdxBusy, "init_busy_o");
    wait_status(IdxInit, "initialized_o");
    inspect_seeds(1'b0);
    compare_value("seed_err_o", seed_err, 1'b0);

    // no provisioning, flash untouched
    apply_reset();
    no_flash = 1'b1;
    init     = 1'b1;
    wait_status(IdxInit, "initialized_o");
    inspect_seeds(1'b1);

    // read error on the seed pages
    apply_reset();
    err_en       = 1'b1;
    provision_en = 1'b1;
    init         = 1'b1;
    wait_status(IdxSeedErr, "seed_err_o");
    wait_status(IdxInit, "initialized_o");
    compare_value("seed_err_o", seed_err, 1'b1);

    // clean wipe from the wait state
    apply_reset();
    init = 1'b1;
    wait_status(IdxInit, "initialized_o");
    rma_req = 1'b1;
    wait_status(IdxAck, "rma_ack_o");
    compare_value("dis_access_o", dis_access, 1'b1);
    compare_value("fatal_err_o", fatal_err, 1'b0);
    confirm_wiped();

    // readback mismatch
    apply_reset();
    flip_en = 1'b1;
    rma_req = 1'b1;
    wait_status(IdxFatal, "fatal_err_o");
    hold_no_ack();

    // program error
    apply_reset();
    err_en  = 1'b1;
    err_op  = FlashOpProgram;
    rma_req = 1'b1;
    wait_status(IdxFatal, "fatal_err_o");
    hold_no_ack();

    // RMA aborts the seed read
    apply_reset();
    provision_en = 1'b1;
    init         = 1'b1;
    wait_status(IdxReq, "flash_req_o");
    rma_req = 1'b1;
    wait_status(IdxAck, "rma_ack_o");
    compare_value("dis_access_o", dis_access, 1'b1);
    compare_value("initialized_o", initialized, 1'b0);

    if (errors == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("Done: errors found");
      $fatal(1);
    end
  end

endmodule

/* verification/flash_model.sv */
// Behavioral flash peer
`timescale 1ns/1ns

module flash_model import lcmgr_pkg::*; #(
  parameter int unsigned BusWidth     = DefBusWidth,
  parameter int unsigned BurstWords   = DefBurstWords,
  parameter int unsigned WordsPerPage = DefWordsPerPage,
  parameter int unsigned AddrWidth    = DefAddrWidth
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  flash_op_e            op_i,
  input  logic [AddrWidth-1:0] addr_i,
  input  logic                 wvalid_i,
  input  logic [BusWidth-1:0]  wdata_i,
  // error injection
  input  logic                 err_en_i,
  input  flash_op_e            err_op_i,
  input  logic                 flip_en_i,
  output logic                 done_o,
  output logic                 err_o,
  output logic                 rvalid_o,
  output logic [BusWidth-1:0]  rdata_o,
  output logic                 wready_o
);

  localparam int unsigned Words = 2 ** AddrWidth;
  localparam int unsigned Pages = Words / WordsPerPage;

  logic [BusWidth-1:0] mem_a [Words];
  // the second read of a page returns this copy
  logic [BusWidth-1:0] mem_b [Words];
  logic erased_q [Words];
  logic prog_q [Words];
  logic [Pages-1:0] pass_q;
  logic busy, cool;
  int unsigned delay, beat, page;
  flash_op_e op_q;
  logic [AddrWidth-1:0] addr_q, word;
  logic done_n, err_n, rvalid_n, wready_n;
  logic [BusWidth-1:0] rdata_n;

  initial begin
    done_o   = 1'b0;
    err_o    = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    wready_o = 1'b0;
    for (int w = 0; w < Words; w++) begin
      mem_a[w] = BusWidth'(32'h9e37_79b9 * (w + 1));
      mem_b[w] = mem_a[w];
    end
  end

  task automatic complete_op();
    done_n = 1'b1;
    err_n  = err_en_i && (err_op_i == op_q);
    busy   = 1'b0;
    // req is stale in the cycle that sees done
    cool   = 1'b1;
    if (op_q == FlashOpRead) begin
      pass_q[page] = ~pass_q[page];
    end
  endtask

  always @(posedge clk_i or negedge rst_ni) begin
    done_n   = 1'b0;
    err_n    = 1'b0;
    rvalid_n = 1'b0;
    wready_n = 1'b0;
    rdata_n  = '0;
    if (!rst_ni) begin
      busy   = 1'b0;
      cool   = 1'b0;
      pass_q = '0;
      for (int w = 0; w < Words; w++) begin
        erased_q[w] = 1'b0;
        prog_q[w]   = 1'b0;
      end
    end else if (cool) begin
      cool = 1'b0;
    end else if (!busy) begin
      if (req_i) begin
        busy   = 1'b1;
        op_q   = op_i;
        addr_q = addr_i;
        beat   = 0;
        delay  = $urandom_range(3, 1);
      end
    end else if (delay > 0) begin
      delay--;
    end else begin
      page = addr_q / WordsPerPage;
      word = addr_q + AddrWidth'(beat);
      case (op_q)
        FlashOpErase: begin
          for (int w = 0; w < WordsPerPage; w++) begin
            mem_a[page * WordsPerPage + w]    = '1;
            mem_b[page * WordsPerPage + w]    = '1;
            erased_q[page * WordsPerPage + w] = 1'b1;
            prog_q[page * WordsPerPage + w]   = 1'b0;
          end
          complete_op();
        end
        FlashOpProgram: begin
          if (wvalid_i && wready_o) begin
            mem_a[word]  = wdata_i;
            mem_b[word]  = wdata_i;
            prog_q[word] = erased_q[word];
            beat++;
          end
          if (beat == BurstWords) begin
            complete_op();
          end else begin
            // random back-pressure
            wready_n = $urandom_range(1, 0);
          end
        end
        default: begin
          if (beat == BurstWords) begin
            complete_op();
          end else begin
            rvalid_n = 1'b1;
            rdata_n  = pass_q[page] ? mem_b[word] : mem_a[word];
            if (flip_en_i && beat == 0) begin
              rdata_n[0] = ~rdata_n[0];
            end
            beat++;
            // done with the last word or one cycle later
            if (beat == BurstWords && $urandom_range(1, 0) == 1) begin
              complete_op();
            end
          end
        end
      endcase
    end
    done_o   <= #1 done_n;
    err_o    <= #1 err_n;
    rvalid_o <= #1 rvalid_n;
    rdata_o  <= #1 rdata_n;
    wready_o <= #1 wready_n;
  end

endmodule

/* design/flash_lcmgr.sv */
// Flash life-cycle manager top level
`timescale 1ns/1ns

module flash_lcmgr import lcmgr_pkg::*; #(
  parameter int unsigned BusWidth     = DefBusWidth,
  parameter int unsigned BurstWords   = DefBurstWords,
  parameter int unsigned NumSeeds     = DefNumSeeds,
  parameter int unsigned WordsPerPage = DefWordsPerPage,
  parameter int unsigned WipePages    = DefWipePages,
  parameter int unsigned AddrWidth    = DefAddrWidth
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // life-cycle side
  input  logic                                    init_i,
  input  logic                                    provision_en_i,
  input  logic                                    rma_req_i,
  output logic                                    rma_ack_o,
  output logic                                    dis_access_o,
  output logic                                    initialized_o,
  output logic                                    init_busy_o,
  output logic                                    seed_err_o,
  output logic                                    fatal_err_o,
  output logic [NumSeeds*BurstWords*BusWidth-1:0] seeds_o,
  // flash port
  output logic                                    flash_req_o,
  output flash_op_e                               flash_op_o,
  output logic [AddrWidth-1:0]                    flash_addr_o,
  input  logic                                    flash_done_i,
  input  logic                                    flash_err_i,
  input  logic                                    flash_rvalid_i,
  input  logic [BusWidth-1:0]                     flash_rdata_i,
  output logic                                    flash_wvalid_o,
  input  logic                                    flash_wready_i,
  output logic [BusWidth-1:0]                     flash_wdata_o,
  input  logic [BusWidth-1:0]                     rand_i
);

  logic seed_active, wipe_active;
  logic seed_done, wipe_done, wipe_err;
  logic seed_req, wipe_req;
  flash_op_e seed_op, wipe_op;
  logic [AddrWidth-1:0] seed_addr, wipe_addr;
  logic seed_done_flash, wipe_done_flash;

  lcmgr_ctrl #(
    .AddrWidth(AddrWidth)
  ) u_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .init_i            (init_i),
    .provision_en_i    (provision_en_i),
    .rma_req_i         (rma_req_i),
    .seed_done_i       (seed_done),
    .wipe_done_i       (wipe_done),
    .wipe_err_i        (wipe_err),
    .seed_active_o     (seed_active),
    .wipe_active_o     (wipe_active),
    .seed_req_i        (seed_req),
    .wipe_req_i        (wipe_req),
    .seed_op_i         (seed_op),
    .wipe_op_i         (wipe_op),
    .seed_addr_i       (seed_addr),
    .wipe_addr_i       (wipe_addr),
    .flash_req_o       (flash_req_o),
    .flash_op_o        (flash_op_o),
    .flash_addr_o      (flash_addr_o),
    .flash_done_i      (flash_done_i),
    .seed_done_flash_o (seed_done_flash),
    .wipe_done_flash_o (wipe_done_flash),
    .rma_ack_o         (rma_ack_o),
    .dis_access_o      (dis_access_o),
    .initialized_o     (initialized_o),
    .init_busy_o       (init_busy_o),
    .fatal_err_o       (fatal_err_o)
  );

  seed_reader #(
    .BusWidth     (BusWidth),
    .BurstWords   (BurstWords),
    .NumSeeds     (NumSeeds),
    .WordsPerPage (WordsPerPage),
    .AddrWidth    (AddrWidth)
  ) u_seed_reader (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .active_i   (seed_active),
    .rvalid_i   (flash_rvalid_i),
    .rdata_i    (flash_rdata_i),
    .done_i     (seed_done_flash),
    .err_i      (flash_err_i),
    .req_o      (seed_req),
    .op_o       (seed_op),
    .addr_o     (seed_addr),
    .done_o     (seed_done),
    .seed_err_o (seed_err_o),
    .seeds_o    (seeds_o)
  );

  rma_wiper #(
    .BusWidth     (BusWidth),
    .BurstWords   (BurstWords),
    .WordsPerPage (WordsPerPage),
    .WipePages    (WipePages),
    .AddrWidth    (AddrWidth)
  ) u_rma_wiper (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .active_i    (wipe_active),
    .done_i      (wipe_done_flash),
    .err_i       (flash_err_i),
    .rvalid_i    (flash_rvalid_i),
    .rdata_i     (flash_rdata_i),
    .wready_i    (flash_wready_i),
    .rand_i      (rand_i),
    .req_o       (wipe_req),
    .op_o        (wipe_op),
    .addr_o      (wipe_addr),
    .wvalid_o    (flash_wvalid_o),
    .wdata_o     (flash_wdata_o),
    .wipe_done_o (wipe_done),
    .wipe_err_o  (wipe_err)
  );

endmodule

/* design/lcmgr_ctrl.sv */
// Life-cycle manager control FSM
`timescale 1ns/1ns

module lcmgr_ctrl import lcmgr_pkg::*; #(
  parameter int unsigned AddrWidth = DefAddrWidth
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 init_i,
  input  logic                 provision_en_i,
  input  logic                 rma_req_i,
  input  logic                 seed_done_i,
  input  logic                 wipe_done_i,
  input  logic                 wipe_err_i,
  output logic                 seed_active_o,
  output logic                 wipe_active_o,
  input  logic                 seed_req_i,
  input  logic                 wipe_req_i,
  input  flash_op_e            seed_op_i,
  input  flash_op_e            wipe_op_i,
  input  logic [AddrWidth-1:0] seed_addr_i,
  input  logic [AddrWidth-1:0] wipe_addr_i,
  output logic                 flash_req_o,
  output flash_op_e            flash_op_o,
  output logic [AddrWidth-1:0] flash_addr_o,
  input  logic                 flash_done_i,
  output logic                 seed_done_flash_o,
  output logic                 wipe_done_flash_o,
  output logic                 rma_ack_o,
  output logic                 dis_access_o,
  output logic                 initialized_o,
  output logic                 init_busy_o,
  output logic                 fatal_err_o
);

  lcmgr_state_e state_q, state_d;
  lcmgr_phase_e phase;

  always_comb begin
    state_d       = state_q;
    phase         = PhaseNone;
    rma_ack_o     = 1'b0;
    dis_access_o  = 1'b0;
    initialized_o = 1'b0;
    fatal_err_o   = 1'b0;
    unique case (state_q)
      StIdle: begin
        if (rma_req_i) begin
          state_d = StRmaWipe;
        end else if (init_i) begin
          state_d = provision_en_i ? StReadSeeds : StWait;
        end
      end
      // abort only between flash transactions
      StReadSeeds: begin
        phase = PhaseSeed;
        if (rma_req_i && !seed_req_i) begin
          state_d = StRmaWipe;
        end else if (seed_done_i) begin
          state_d = StWait;
        end
      end
      StWait: begin
        initialized_o = 1'b1;
        if (rma_req_i) begin
          state_d = StRmaWipe;
        end
      end
      StRmaWipe: begin
        phase = PhaseRma;
        if (wipe_done_i) begin
          state_d = wipe_err_i ? StInvalid : StRmaRsp;
        end
      end
      StRmaRsp: begin
        dis_access_o = 1'b1;
        rma_ack_o    = rma_req_i;
      end
      StInvalid: begin
        dis_access_o = 1'b1;
        fatal_err_o  = 1'b1;
      end
      default: begin
        dis_access_o = 1'b1;
        fatal_err_o  = 1'b1;
        state_d      = StInvalid;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StIdle;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////
  // flash port mux
  //////////////////////////////
  assign seed_active_o = phase == PhaseSeed;
  assign wipe_active_o = phase == PhaseRma;
  assign init_busy_o   = seed_active_o;

  assign flash_req_o  = seed_active_o ? seed_req_i :
                        wipe_active_o ? wipe_req_i : 1'b0;
  assign flash_op_o   = wipe_active_o ? wipe_op_i : seed_op_i;
  assign flash_addr_o = wipe_active_o ? wipe_addr_i : seed_addr_i;

  assign seed_done_flash_o = flash_done_i && seed_active_o;
  assign wipe_done_flash_o = flash_done_i && wipe_active_o;

endmodule

/* design/rma_wiper.sv */
// RMA flash wiper
`timescale 1ns/1ns

module rma_wiper import lcmgr_pkg::*; #(
  parameter int unsigned BusWidth     = DefBusWidth,
  parameter int unsigned BurstWords   = DefBurstWords,
  parameter int unsigned WordsPerPage = DefWordsPerPage,
  parameter int unsigned WipePages    = DefWipePages,
  parameter int unsigned AddrWidth    = DefAddrWidth
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 active_i,
  input  logic                 done_i,
  input  logic                 err_i,
  input  logic                 rvalid_i,
  input  logic [BusWidth-1:0]  rdata_i,
  input  logic                 wready_i,
  input  logic [BusWidth-1:0]  rand_i,
  output logic                 req_o,
  output flash_op_e            op_o,
  output logic [AddrWidth-1:0] addr_o,
  output logic                 wvalid_o,
  output logic [BusWidth-1:0]  wdata_o,
  output logic                 wipe_done_o,
  output logic                 wipe_err_o
);

  localparam int unsigned PageCntW = $clog2(WipePages + 1);
  localparam int unsigned WordCntW = $clog2(WordsPerPage + 1);
  localparam int unsigned BeatCntW = $clog2(BurstWords + 1);

  wipe_state_e state_q, state_d;
  logic [PageCntW-1:0] page_cnt_q;
  logic [WordCntW-1:0] word_cnt_q;
  logic [BeatCntW-1:0] beat_cnt_q;
  logic [BurstWords-1:0][BusWidth-1:0] prog_data_q;
  logic err_q, err_set;
  logic gap_q, req;
  logic page_clr, page_incr, word_clr, word_incr, beat_clr, beat_incr;
  logic last_beat, mismatch;

  assign last_beat = beat_cnt_q == BeatCntW'(BurstWords - 1);
  assign mismatch  = prog_data_q[beat_cnt_q] != rdata_i;

  //////////////////////////////
  // wipe FSM
  //////////////////////////////
  always_comb begin
    state_d     = state_q;
    req         = 1'b0;
    op_o        = FlashOpRead;
    wvalid_o    = 1'b0;
    wipe_done_o = 1'b0;
    err_set     = 1'b0;
    page_clr    = 1'b0;
    page_incr   = 1'b0;
    word_clr    = 1'b0;
    word_incr   = 1'b0;
    beat_clr    = 1'b0;
    beat_incr   = 1'b0;
    unique case (state_q)
      StWipeIdle: begin
        if (active_i) begin
          page_clr = 1'b1;
          state_d  = StWipePageSel;
        end
      end
      StWipePageSel: begin
        if (page_cnt_q < PageCntW'(WipePages)) begin
          word_clr = 1'b1;
          state_d  = StWipeErase;
        end else begin
          wipe_done_o = 1'b1;
          state_d     = StWipeIdle;
        end
      end
      StWipeErase: begin
        req  = 1'b1;
        op_o = FlashOpErase;
        if (done_i) begin
          err_set = err_i;
          state_d = err_i ? StWipeInvalid : StWipeWordSel;
        end
      end
      StWipeWordSel: begin
        if (word_cnt_q < WordCntW'(WordsPerPage)) begin
          beat_clr = 1'b1;
          state_d  = StWipeProgram;
        end else begin
          page_incr = 1'b1;
          state_d   = StWipePageSel;
        end
      end
      // beat holds until wready
      StWipeProgram: begin
        req      = 1'b1;
        op_o     = FlashOpProgram;
        wvalid_o = 1'b1;
        if (wready_i) begin
          beat_incr = 1'b1;
          if (last_beat) begin
            state_d = StWipeProgramWait;
          end
        end
      end
      StWipeProgramWait: begin
        req  = 1'b1;
        op_o = FlashOpProgram;
        if (done_i) begin
          err_set  = err_i;
          beat_clr = 1'b1;
          state_d  = err_i ? StWipeInvalid : StWipeRdVerify;
        end
      end
      StWipeRdVerify: begin
        req = 1'b1;
        if (rvalid_i) begin
          beat_incr = 1'b1;
          err_set   = mismatch;
        end
        // done may come together with the last rvalid
        if (done_i) begin
          err_set   = err_set | err_i;
          beat_clr  = 1'b1;
          word_incr = 1'b1;
          state_d   = (err_q || err_set) ? StWipeInvalid : StWipeWordSel;
        end
      end
      // terminal, keeps reporting while still selected
      StWipeInvalid: begin
        wipe_done_o = active_i;
      end
      default: begin
        state_d = StWipeInvalid;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= StWipeIdle;
      page_cnt_q <= '0;
      word_cnt_q <= '0;
      beat_cnt_q <= '0;
      err_q      <= 1'b0;
      gap_q      <= 1'b0;
    end else begin
      state_q <= state_d;
      err_q   <= err_q | err_set;
      gap_q   <= done_i;
      if (page_clr) begin
        page_cnt_q <= '0;
      end else if (page_incr) begin
        page_cnt_q <= page_cnt_q + 1'b1;
      end
      if (word_clr) begin
        word_cnt_q <= '0;
      end else if (word_incr) begin
        word_cnt_q <= word_cnt_q + WordCntW'(BurstWords);
      end
      if (beat_clr) begin
        beat_cnt_q <= '0;
      end else if (beat_incr) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
    end
  end

  // burst data kept for readback compare
  always_ff @(posedge clk_i) begin
    if (wvalid_o && wready_i) begin
      prog_data_q[beat_cnt_q] <= rand_i;
    end
  end

  // req drops for one cycle after every done
  assign req_o      = req && !gap_q;
  assign addr_o     = AddrWidth'(page_cnt_q * WordsPerPage + word_cnt_q);
  assign wdata_o    = rand_i;
  assign wipe_err_o = err_q;

endmodule

/* design/seed_reader.sv */
// Flash seed reader
`timescale 1ns/1ns

module seed_reader import lcmgr_pkg::*; #(
  parameter int unsigned BusWidth     = DefBusWidth,
  parameter int unsigned BurstWords   = DefBurstWords,
  parameter int unsigned NumSeeds     = DefNumSeeds,
  parameter int unsigned WordsPerPage = DefWordsPerPage,
  parameter int unsigned AddrWidth    = DefAddrWidth
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   active_i,
  input  logic                                   rvalid_i,
  input  logic [BusWidth-1:0]                    rdata_i,
  input  logic                                   done_i,
  input  logic                                   err_i,
  output logic                                   req_o,
  output flash_op_e                              op_o,
  output logic [AddrWidth-1:0]                   addr_o,
  output logic                                   done_o,
  output logic                                   seed_err_o,
  output logic [NumSeeds*BurstWords*BusWidth-1:0] seeds_o
);

  localparam int unsigned SeedCntW = $clog2(NumSeeds + 1);
  localparam int unsigned WordCntW = $clog2(BurstWords + 1);

  logic [NumSeeds-1:0][BurstWords-1:0][BusWidth-1:0] seeds_q;
  logic [SeedCntW-1:0] seed_cnt_q;
  logic [WordCntW-1:0] word_cnt_q;
  // second pass of the current seed
  logic validate_q;
  logic gap_q;
  logic done_q;
  logic seed_err_q;
  logic reading;

  assign reading = active_i && (seed_cnt_q < SeedCntW'(NumSeeds));

  // req drops for one cycle after every done
  assign req_o  = reading && !gap_q;
  assign op_o   = FlashOpRead;
  // seed i sits at the start of page i
  assign addr_o = AddrWidth'(seed_cnt_q * WordsPerPage);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seed_cnt_q <= '0;
      word_cnt_q <= '0;
      validate_q <= 1'b0;
      gap_q      <= 1'b0;
      done_q     <= 1'b0;
      seed_err_q <= 1'b0;
    end else begin
      gap_q  <= done_i;
      done_q <= done_i && validate_q && (seed_cnt_q == SeedCntW'(NumSeeds - 1));
      if (reading && rvalid_i) begin
        word_cnt_q <= word_cnt_q + 1'b1;
      end
      if (reading && done_i) begin
        word_cnt_q <= '0;
        validate_q <= !validate_q;
        if (validate_q) begin
          seed_cnt_q <= seed_cnt_q + 1'b1;
        end
        // sticky, reading goes on
        if (err_i) begin
          seed_err_q <= 1'b1;
        end
      end
    end
  end

  // first pass stores, second pass ANDs in
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seeds_q <= '0;
    end else if (reading && rvalid_i) begin
      if (validate_q) begin
        seeds_q[seed_cnt_q][word_cnt_q] <= seeds_q[seed_cnt_q][word_cnt_q] & rdata_i;
      end else begin
        seeds_q[seed_cnt_q][word_cnt_q] <= rdata_i;
      end
    end
  end

  assign done_o     = done_q;
  assign seed_err_o = seed_err_q;
  assign seeds_o    = seeds_q;

endmodule

/* design/lcmgr_pkg.sv */
// Life-cycle manager shared types
package lcmgr_pkg;

  //////////////////////////////
  // default parameter values
  //////////////////////////////

  // flash data word width
  parameter int unsigned DefBusWidth     = 32;
  // words per read or program burst, also words per seed
  parameter int unsigned DefBurstWords   = 4;
  parameter int unsigned DefNumSeeds     = 2;
  // must be a multiple of the burst
  parameter int unsigned DefWordsPerPage = 16;
  parameter int unsigned DefWipePages    = 4;
  parameter int unsigned DefAddrWidth    = 8;

  //////////////////////////////
  // enums
  //////////////////////////////

  typedef enum logic [1:0] {
    FlashOpRead    = 2'd0,
    FlashOpProgram = 2'd1,
    FlashOpErase   = 2'd2
  } flash_op_e;

  // who owns the flash port
  typedef enum logic [1:0] {
    PhaseNone = 2'd0,
    PhaseSeed = 2'd1,
    PhaseRma  = 2'd2
  } lcmgr_phase_e;

  typedef enum logic [2:0] {
    StIdle      = 3'd0,
    StReadSeeds = 3'd1,
    StWait      = 3'd2,
    StRmaWipe   = 3'd3,
    StRmaRsp    = 3'd4,
    StInvalid   = 3'd5
  } lcmgr_state_e;

  typedef enum logic [2:0] {
    StWipeIdle        = 3'd0,
    StWipePageSel     = 3'd1,
    StWipeErase       = 3'd2,
    StWipeWordSel     = 3'd3,
    StWipeProgram     = 3'd4,
    StWipeProgramWait = 3'd5,
    StWipeRdVerify    = 3'd6,
    StWipeInvalid     = 3'd7
  } wipe_state_e;

endpackage
